// File: list.f
+incdir+logic
+incdir+verification
logic/mipsPkg.sv
logic/controlUnit.sv
logic/registerFile.sv
logic/alu.sv
logic/dataMemory.sv
logic/mipsDatapath.sv
verification/tbMipsDatapath.sv

// File: Bender.yml
package:
  name: mips_datapath

sources:
  - include_dirs:
      - logic
    files:
      - logic/mipsPkg.sv
      - logic/controlUnit.sv
      - logic/registerFile.sv
      - logic/alu.sv
      - logic/dataMemory.sv
      - logic/mipsDatapath.sv
  - target: test
    include_dirs:
      - logic
      - verification
    files:
      - verification/tbMipsDatapath.sv

// File: verification/refModel.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

////////////////////////////////////////////////////////////
// Architectural state, updated in program order
////////////////////////////////////////////////////////////

wordT modelRegs [32];
wordT modelMem [`DMEM_WORDS];

typedef enum {evNone, evWb, evStore, evBranch, evError} evKindT;

typedef struct {
	int       due;   // Cycle in which the ports show it
	evKindT   kind;
	regIdxT   dest;
	wordT     data;  // Writeback value, store lanes or branch offset
	wordT     addr;
	byteMaskT bytes;
	logic     taken;
} expEventT;

function automatic void clearModel();
	for (int i = 0; i < 32; i++)
		modelRegs[i] = '0;
	for (int w = 0; w < `DMEM_WORDS; w++)
		modelMem[w] = '0;
endfunction

// Bytes moved by a load or store
function automatic int accessSize(opcodeT op);
	case (op)
		`OP_LB, `OP_LBU, `OP_SB: return 1;
		`OP_LH, `OP_LHU, `OP_SH: return 2;
		default:                 return 4;
	endcase
endfunction

function automatic int memIndex(wordT addr);
	return int'((addr >> 2) % `DMEM_WORDS); // Word index wraps on the depth
endfunction

////////////////////////////////////////////////////////////
// One instruction, returns the event it must produce
////////////////////////////////////////////////////////////

function automatic expEventT runModel(wordT ins);
	expEventT e;
	opcodeT   op;
	wordT     a;
	wordT     b;
	wordT     sImm;
	wordT     zImm;
	wordT     word;
	wordT     lanes;
	int       nb;
	int       off;
	logic     isUns;
	op = ins[31:26];
	a = modelRegs[ins[25:21]];
	b = modelRegs[ins[20:16]];
	sImm = {{16{ins[15]}}, ins[15:0]};
	zImm = {16'h0, ins[15:0]};
	e.due = 0;
	e.kind = evWb; // Most instructions write rt
	e.dest = ins[20:16];
	e.data = '0;
	e.addr = '0;
	e.bytes = '0;
	e.taken = 1'b0;
	case (op)
		`OP_RTYPE:
		begin
			e.dest = ins[15:11];
			case (ins[5:0])
				`FN_ADD:  e.data = a + b;
				`FN_SUB:  e.data = a - b;
				`FN_AND:  e.data = a & b;
				`FN_OR:   e.data = a | b;
				`FN_XOR:  e.data = a ^ b;
				`FN_NOR:  e.data = ~(a | b);
				`FN_SLT:  e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				`FN_SLL:  e.data = b << ins[10:6];
				`FN_SRL:  e.data = b >> ins[10:6];
				`FN_SRA:  e.data = wordT'($signed(b) >>> ins[10:6]);
				`FN_SLLV: e.data = b << a[4:0];
				`FN_SRLV: e.data = b >> a[4:0];
				`FN_SRAV: e.data = wordT'($signed(b) >>> a[4:0]);
				default:  e.kind = evError;
			endcase
		end
		`OP_ADDI: e.data = a + sImm;
		`OP_SLTI: e.data = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
		`OP_ANDI: e.data = a & zImm;
		`OP_ORI:  e.data = a | zImm;
		`OP_XORI: e.data = a ^ zImm;
		`OP_LUI:  e.data = {ins[15:0], 16'h0};
		`OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW, `OP_LWU:
		begin
			e.addr = a + sImm;
			nb = accessSize(op);
			isUns = (op == `OP_LBU) || (op == `OP_LHU);
			word = modelMem[memIndex(e.addr)] >> (8 * e.addr[1:0]); // Addressed byte to bit 0
			if (nb == 1)
				e.data = isUns ? {24'h0, word[7:0]} : {{24{word[7]}}, word[7:0]};
			else if (nb == 2)
				e.data = isUns ? {16'h0, word[15:0]} : {{16{word[15]}}, word[15:0]};
			else
				e.data = word;
		end
		`OP_SB, `OP_SH, `OP_SW:
		begin
			e.kind = evStore;
			e.addr = a + sImm;
			nb = accessSize(op);
			off = e.addr[1:0];
			case (nb)
				1:       lanes = {24'h0, b[7:0]};
				2:       lanes = {16'h0, b[15:0]};
				default: lanes = b;
			endcase
			e.data = lanes << (8 * off);
			e.bytes = byteMaskT'(((1 << nb) - 1) << off);
			for (int i = 0; i < 4; i++)
				if (e.bytes[i])
					modelMem[memIndex(e.addr)][8*i +: 8] = e.data[8*i +: 8];
		end
		`OP_BEQ, `OP_BNE:
		begin
			e.kind = evBranch;
			e.taken = (op == `OP_BEQ) ? (a == b) : (a != b);
			e.data = sImm << 2;
		end
		default: e.kind = evError;
	endcase
	if (e.kind == evWb)
	begin
		if (e.dest == '0)
			e.kind = evNone; // r0 swallows the write
		else
			modelRegs[e.dest] = e.data;
	end
	return e;
endfunction

`endif

// File: verification/tbMipsDatapath.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module tbMipsDatapath;
	import mipsPkg::*;

	`include "refModel.svh"

	logic     clk;
	logic     arstN;
	logic     instrValid;
	wordT     instr;
	logic     wbValid;
	regIdxT   wbReg;
	wordT     wbData;
	logic     storeValid;
	wordT     storeAddr;
	wordT     storeData;
	byteMaskT storeBytes;
	logic     branchTaken;
	wordT     branchOffset;
	logic     decodeError;

	expEventT expQ [$]; // Ordered by due cycle
	int       cycle;    // Issue slots so far
	int       issued;

	// Generator pools
	functT  goodFns [13] = '{`FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV,
		`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_XOR, `FN_NOR, `FN_SLT};
	opcodeT immOps [6] = '{`OP_ADDI, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI};
	opcodeT loadOps [6] = '{`OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW, `OP_LWU};
	opcodeT storeOps [3] = '{`OP_SB, `OP_SH, `OP_SW};
	opcodeT badOps [5] = '{6'b000010, 6'b000011, 6'b000110, 6'b100010, 6'b111111};
	functT  badFns [4] = '{6'b001000, 6'b011000, 6'b100001, 6'b000001};

	mipsDatapath dut (
		.clk(clk), .arstN(arstN), .instrValid(instrValid), .instr(instr),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
		.storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData),
		.storeBytes(storeBytes), .branchTaken(branchTaken), .branchOffset(branchOffset),
		.decodeError(decodeError)
	);

	always #4 clk = ~clk; // 8 ns period

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic failNow(string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic expectFlag(string name, logic got, logic exp);
		if (got !== exp)
			failNow($sformatf("Fail %s got %h expected %h", name, got, exp));
	endtask

	task automatic checkWb(regIdxT expReg, wordT expData);
		if (wbReg !== expReg)
			failNow($sformatf("Fail wbReg got %h expected %h", wbReg, expReg));
		if (wbData !== expData)
			failNow($sformatf("Fail wbData got %h expected %h", wbData, expData));
	endtask

	task automatic checkStore(wordT expAddr, wordT expData, byteMaskT expBytes);
		if (storeAddr !== expAddr)
			failNow($sformatf("Fail storeAddr got %h expected %h", storeAddr, expAddr));
		if (storeData !== expData)
			failNow($sformatf("Fail storeData got %h expected %h", storeData, expData));
		if (storeBytes !== expBytes)
			failNow($sformatf("Fail storeBytes got %h expected %h", storeBytes, expBytes));
	endtask

	task automatic checkBranch(logic expTaken, wordT expOffset);
		expectFlag("branchTaken", branchTaken, expTaken);
		if (branchOffset !== expOffset)
			failNow($sformatf("Fail branchOffset got %h expected %h", branchOffset, expOffset));
	endtask

	// Squashed instruction leaves no side effect
	task automatic checkIllegal();
		expectFlag("decodeError", decodeError, 1'b1);
		expectFlag("wbValid", wbValid, 1'b0);
		expectFlag("storeValid", storeValid, 1'b0);
		expectFlag("branchTaken", branchTaken, 1'b0);
	endtask

	task automatic compareOutputs();
		expEventT e;
		e.kind = evNone; // Idle unless an event is due now
		if (expQ.size() > 0 && expQ[0].due == cycle)
			e = expQ.pop_front();
		if (e.kind != evError)
		begin
			expectFlag("wbValid", wbValid, e.kind == evWb);
			expectFlag("storeValid", storeValid, e.kind == evStore);
			expectFlag("decodeError", decodeError, 1'b0);
			if (e.kind != evBranch)
				expectFlag("branchTaken", branchTaken, 1'b0);
		end
		case (e.kind)
			evWb:     checkWb(e.dest, e.data);
			evStore:  checkStore(e.addr, e.data, e.bytes);
			evBranch: checkBranch(e.taken, e.data);
			evError:  checkIllegal();
			default:  ;
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	function automatic regIdxT pickReg();
		if ($urandom_range(0, 3) != 0)
			return regIdxT'($urandom_range(0, 4)); // Few hot registers, many dependencies
		return regIdxT'($urandom_range(0, 31));
	endfunction

	function automatic logic [15:0] randomImm();
		if ($urandom_range(0, 1) == 0)
			return 16'($urandom_range(0, 16) - 8); // Small, either sign
		return 16'($urandom);
	endfunction

	function automatic wordT randomInstr();
		int     pick;
		regIdxT rs;
		regIdxT rt;
		opcodeT op;
		wordT   target;
		wordT   diff;
		rs = pickReg();
		rt = pickReg();
		pick = $urandom_range(0, 99);
		if (pick < 35)
			return {`OP_RTYPE, rs, rt, pickReg(), 5'($urandom_range(0, 31)),
				goodFns[$urandom_range(0, 12)]};
		if (pick < 55)
			return {immOps[$urandom_range(0, 5)], rs, rt, randomImm()};
		if (pick < 85)
		begin
			op = (pick < 70) ? storeOps[$urandom_range(0, 2)] : loadOps[$urandom_range(0, 5)];
			// Aligned target low in memory, reached from the base register's model value
			target = wordT'($urandom_range(0, 127)) & ~wordT'(accessSize(op) - 1);
			diff = target - modelRegs[rs];
			if ($signed(diff) < -32768 || $signed(diff) > 32767)
			begin
				rs = '0; // Base out of reach, use r0
				diff = target;
			end
			return {op, rs, rt, diff[15:0]};
		end
		if (pick < 95)
		begin
			if ($urandom_range(0, 2) == 0)
				rt = rs; // Equal operands
			return {($urandom_range(0, 1) == 0) ? `OP_BEQ : `OP_BNE, rs, rt, randomImm()};
		end
		if (pick < 98)
			return {badOps[$urandom_range(0, 4)], rs, rt, 16'($urandom)};
		return {`OP_RTYPE, rs, rt, pickReg(), 5'd0, badFns[$urandom_range(0, 3)]};
	endfunction

	// Check this cycle, then drive the next slot
	task automatic stepCycle(logic valid, wordT word);
		expEventT e;
		@(negedge clk);
		cycle++;
		compareOutputs();
		instrValid = valid;
		instr = word;
		if (valid)
		begin
			e = runModel(word);
			e.due = cycle + 2;
			expQ.push_back(e);
			issued++;
		end
	endtask

	task automatic waitIdle(int limit);
		int waited;
		waited = 0;
		while (wbValid !== 1'b0 || storeValid !== 1'b0 || branchTaken !== 1'b0
			|| decodeError !== 1'b0)
		begin
			if (waited == limit)
				failNow("DUT result ports stayed busy after reset release");
			@(negedge clk);
			waited++;
		end
	endtask

	initial
	begin
		int seedDone;
		int guard;
		seedDone = $urandom(32'h286c);
		clk = 1'b0;
		arstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		cycle = 0;
		issued = 0;
		clearModel();
		repeat (8) @(negedge clk);
		arstN = 1'b1;
		waitIdle(16);

		// Every register against r0, read only
		for (int r = 1; r < 32; r++)
			stepCycle(1'b1, {`OP_BEQ, 5'(r), 5'd0, randomImm()});

		guard = 0;
		while (issued < 3000)
		begin
			if (guard == 20000)
				failNow("Random stream did not reach its instruction count");
			guard++;
			if ($urandom_range(0, 9) < 8)
				stepCycle(1'b1, randomInstr());
			else
				stepCycle(1'b0, $urandom); // Junk word while the strobe is low
		end

		guard = 0;
		while (expQ.size() > 0)
		begin
			if (guard == 10)
				failNow("Expected events still pending after the drain");
			guard++;
			stepCycle(1'b0, '0);
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

// File: logic/mipsDatapath.sv
`timescale 1ns/1ps

module mipsDatapath (
	input  logic              clk,
	input  logic              arstN,
	input  logic              instrValid,
	input  mipsPkg::wordT     instr,
	output logic              wbValid,
	output mipsPkg::regIdxT   wbReg,
	output mipsPkg::wordT     wbData,
	output logic              storeValid,
	output mipsPkg::wordT     storeAddr,
	output mipsPkg::wordT     storeData,
	output mipsPkg::byteMaskT storeBytes,
	output logic              branchTaken,
	output mipsPkg::wordT     branchOffset,
	output logic              decodeError
);
	import mipsPkg::*;

	// Decode stage
	regIdxT   instrRs;
	regIdxT   instrRt;
	regIdxT   instrRd;
	logic [15:0] instrImm;
	wordT     decImm;
	regIdxT   decDest;
	wordT     rsData;
	wordT     rtData;
	aluOpT    decAluOp;
	shiftSrcT decShiftSrc;
	byteMaskT decReadBytes;
	byteMaskT decWriteBytes;
	logic     decRegWrite;
	logic     decMemToReg;
	logic     decMemWrite;
	logic     decBranch;
	logic     decBranchNe;
	logic     decAluSrc;
	logic     decRegDst;
	logic     decImmZeroExt;
	logic     decLoadUnsigned;
	logic     decIllegal;

	// Execute register
	aluOpT    exAluOp;
	shiftSrcT exShiftSrc;
	byteMaskT exReadBytes;
	byteMaskT exWriteBytes;
	logic     exRegWrite;
	logic     exMemToReg;
	logic     exMemWrite;
	logic     exBranch;
	logic     exBranchNe;
	logic     exAluSrc;
	logic     exLoadUnsigned;
	logic     exIllegal;
	wordT     exRsData;
	wordT     exRtData;
	wordT     exImm;
	shamtT    exShamt;
	regIdxT   exDest;
	regIdxT   exRsIdx;
	regIdxT   exRtIdx;

	// Execute stage
	wordT     fwdA;
	wordT     fwdB;
	wordT     aluB;
	shamtT    aluShamt;
	wordT     aluResult;
	logic     aluZero;
	wordT     memReadData;
	wordT     memLaneData;
	byteMaskT memLaneEnables;
	logic     wbNext;

	////////////////////////////////////////////////////////////
	// Decode and register read, cycle c
	////////////////////////////////////////////////////////////

	assign instrRs  = instr[25:21];
	assign instrRt  = instr[20:16];
	assign instrRd  = instr[15:11];
	assign instrImm = instr[15:0];

	controlUnit uControl (
		.op(instr[31:26]), .funct(instr[5:0]), .aluOp(decAluOp),
		.regWrite(decRegWrite), .memToReg(decMemToReg), .memWrite(decMemWrite),
		.branch(decBranch), .branchNe(decBranchNe), .aluSrc(decAluSrc),
		.regDst(decRegDst), .immZeroExt(decImmZeroExt), .loadUnsigned(decLoadUnsigned),
		.illegal(decIllegal), .shiftSrc(decShiftSrc), .readBytes(decReadBytes),
		.writeBytes(decWriteBytes)
	);

	assign decImm  = decImmZeroExt ? {16'h0, instrImm} : {{16{instrImm[15]}}, instrImm};
	assign decDest = decRegDst ? instrRd : instrRt; // rd for R-type, else rt

	registerFile uRegs (
		.clk(clk), .arstN(arstN),
		.readAddrA(instrRs), .readAddrB(instrRt),
		.readDataA(rsData), .readDataB(rtData),
		.writeEn(wbValid), .writeAddr(wbReg), .writeData(wbData) // Writes at end of c+2
	);

	// Controls drop to zero on an empty slot
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			exAluOp        <= aluAdd;
			exShiftSrc     <= shiftShamt;
			exReadBytes    <= '0;
			exWriteBytes   <= '0;
			exRegWrite     <= 1'b0;
			exMemToReg     <= 1'b0;
			exMemWrite     <= 1'b0;
			exBranch       <= 1'b0;
			exBranchNe     <= 1'b0;
			exAluSrc       <= 1'b0;
			exLoadUnsigned <= 1'b0;
			exIllegal      <= 1'b0;
		end
		else
		begin
			exAluOp        <= decAluOp;
			exShiftSrc     <= decShiftSrc;
			exReadBytes    <= instrValid ? decReadBytes : 4'b0000;
			exWriteBytes   <= instrValid ? decWriteBytes : 4'b0000;
			exRegWrite     <= instrValid && decRegWrite;
			exMemToReg     <= decMemToReg;
			exMemWrite     <= instrValid && decMemWrite;
			exBranch       <= instrValid && decBranch;
			exBranchNe     <= decBranchNe;
			exAluSrc       <= decAluSrc;
			exLoadUnsigned <= decLoadUnsigned;
			exIllegal      <= instrValid && decIllegal;
		end
	end

	always_ff @(posedge clk)
	begin
		if (instrValid)
		begin
			exRsData <= rsData;
			exRtData <= rtData;
			exImm    <= decImm;
			exShamt  <= instr[10:6];
			exDest   <= decDest;
			exRsIdx  <= instrRs;
			exRtIdx  <= instrRt;
		end
	end

	////////////////////////////////////////////////////////////
	// Execute and memory, cycle c+1
	////////////////////////////////////////////////////////////

	// Result of the previous instruction sits in the writeback register
	assign fwdA = (wbValid && (wbReg == exRsIdx)) ? wbData : exRsData;
	assign fwdB = (wbValid && (wbReg == exRtIdx)) ? wbData : exRtData;
	assign aluB = exAluSrc ? exImm : fwdB;

	always_comb
	begin
		case (exShiftSrc)
			shiftRs:      aluShamt = fwdA[4:0];
			shiftSixteen: aluShamt = 5'd16;   // LUI
			default:      aluShamt = exShamt;
		endcase
	end

	alu uAlu (
		.op(exAluOp), .a(fwdA), .b(aluB), .shamt(aluShamt),
		.result(aluResult), .zero(aluZero)
	);

	dataMemory uDmem (
		.clk(clk), .arstN(arstN), .addr(aluResult),
		.writeEn(exMemWrite), .writeData(fwdB),
		.writeBytes(exWriteBytes), .readBytes(exReadBytes),
		.loadUnsigned(exLoadUnsigned), .readData(memReadData),
		.laneData(memLaneData), .laneEnables(memLaneEnables)
	);

	assign wbNext = exRegWrite && (exDest != '0); // r0 writes vanish here

	////////////////////////////////////////////////////////////
	// Result registers, visible in cycle c+2
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			wbValid      <= 1'b0;
			wbReg        <= '0;
			wbData       <= '0;
			storeValid   <= 1'b0;
			storeAddr    <= '0;
			storeData    <= '0;
			storeBytes   <= '0;
			branchTaken  <= 1'b0;
			branchOffset <= '0;
			decodeError  <= 1'b0;
		end
		else
		begin
			wbValid     <= wbNext;
			storeValid  <= exMemWrite;
			branchTaken <= exBranch && (aluZero ^ exBranchNe); // BNE inverts
			decodeError <= exIllegal;
			if (wbNext)
			begin
				wbReg  <= exDest;
				wbData <= exMemToReg ? memReadData : aluResult;
			end
			if (exMemWrite)
			begin
				storeAddr  <= aluResult;
				storeData  <= memLaneData;
				storeBytes <= memLaneEnables;
			end
			if (exBranch)
				branchOffset <= {exImm[29:0], 2'b00}; // Times four
		end
	end

	// Forwarding would mistake r0 for a live result
	noZeroWriteback: assert property (@(posedge clk) disable iff (!arstN)
		wbValid |-> (wbReg != '0))
		else $error("mipsDatapath: writeback to r0");

endmodule

// File: logic/dataMemory.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module dataMemory (
	input  logic              clk,
	input  logic              arstN,
	input  mipsPkg::wordT     addr,
	input  logic              writeEn,
	input  mipsPkg::wordT     writeData,
	input  mipsPkg::byteMaskT writeBytes,
	input  mipsPkg::byteMaskT readBytes,
	input  logic              loadUnsigned,
	output mipsPkg::wordT     readData,
	output mipsPkg::wordT     laneData,
	output mipsPkg::byteMaskT laneEnables
);
	import mipsPkg::*;

	localparam int idxWidth = $clog2(`DMEM_WORDS);

	wordT            mem [`DMEM_WORDS];
	logic [idxWidth-1:0] wordIdx; // Upper address bits wrap on the depth
	logic [1:0]      byteOff;
	wordT            replData;    // Store data copied into every lane
	wordT            readWord;
	logic [7:0]      readByte;
	logic [15:0]     readHalf;
	byteMaskT        accessBytes; // Lanes touched this cycle

	assign wordIdx = addr[idxWidth+1:2];
	assign byteOff = addr[1:0];

	////////////////////////////////////////////////////////////
	// Store lane placement
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (writeBytes)
			4'b0001: replData = {4{writeData[7:0]}};
			4'b0011: replData = {2{writeData[15:0]}};
			default: replData = writeData;
		endcase
		laneEnables = writeBytes << byteOff; // Mask slid to the offset
		for (int i = 0; i < 4; i++)
			laneData[8*i +: 8] = laneEnables[i] ? replData[8*i +: 8] : 8'h00;
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int w = 0; w < `DMEM_WORDS; w++)
				mem[w] <= '0;
		end
		else if (writeEn)
		begin
			for (int i = 0; i < 4; i++)
				if (laneEnables[i])
					mem[wordIdx][8*i +: 8] <= laneData[8*i +: 8];
		end
	end

	////////////////////////////////////////////////////////////
	// Load extraction
	////////////////////////////////////////////////////////////

	assign readWord = mem[wordIdx];
	assign readByte = readWord[8*byteOff +: 8];
	assign readHalf = readWord[16*byteOff[1] +: 16];

	always_comb
	begin
		case (readBytes)
			4'b0001: readData = loadUnsigned ? {24'h0, readByte} : {{24{readByte[7]}}, readByte};
			4'b0011: readData = loadUnsigned ? {16'h0, readHalf} : {{16{readHalf[15]}}, readHalf};
			default: readData = readWord; // LW and LWU alike on 32 bits
		endcase
	end

	// Half needs an even address, word needs offset zero
	assign accessBytes = readBytes | (writeEn ? writeBytes : 4'b0000);

	alignedAccess: assert property (@(posedge clk) disable iff (!arstN)
		!(accessBytes[1] && byteOff[0]) && !(accessBytes[3] && byteOff[1]))
		else $error("dataMemory: misaligned access, addr %h lanes %b", addr, accessBytes);

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
	input  mipsPkg::aluOpT op,
	input  mipsPkg::wordT  a,
	input  mipsPkg::wordT  b,
	input  mipsPkg::shamtT shamt,
	output mipsPkg::wordT  result,
	output logic           zero
);
	import mipsPkg::*;

	logic lessThan; // Signed a below b

	assign lessThan = ($signed(a) < $signed(b));

	always_comb
	begin
		case (op)
			aluAdd:  result = a + b;
			aluSub:  result = a - b;
			aluAnd:  result = a & b;
			aluOr:   result = a | b;
			aluXor:  result = a ^ b;
			aluNor:  result = ~(a | b);
			aluSll:  result = b << shamt;             // Shifts act on b
			aluSrl:  result = b >> shamt;
			aluSra:  result = wordT'($signed(b) >>> shamt); // Sign fill
			aluSlt:  result = {31'b0, lessThan};
			default: result = '0;
		endcase
	end

	assign zero = (result == '0); // Equal compare for BEQ and BNE

endmodule

// File: logic/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input  logic            clk,
	input  logic            arstN,
	input  mipsPkg::regIdxT readAddrA,
	input  mipsPkg::regIdxT readAddrB,
	output mipsPkg::wordT   readDataA,
	output mipsPkg::wordT   readDataB,
	input  logic            writeEn,
	input  mipsPkg::regIdxT writeAddr,
	input  mipsPkg::wordT   writeData
);
	import mipsPkg::*;

	wordT regs [32];
	logic writeLive; // Write that actually lands

	assign writeLive = writeEn && (writeAddr != '0); // r0 ignores writes

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int r = 0; r < 32; r++)
				regs[r] <= '0;
		end
		else if (writeLive)
			regs[writeAddr] <= writeData;
	end

	// r0 reads zero, same-cycle write passes straight through
	assign readDataA = (readAddrA == '0) ? '0 :
		(writeLive && (writeAddr == readAddrA)) ? writeData : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 :
		(writeLive && (writeAddr == readAddrB)) ? writeData : regs[readAddrB];

endmodule

// File: logic/controlUnit.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module controlUnit (
	input  mipsPkg::opcodeT   op,
	input  mipsPkg::functT    funct,
	output mipsPkg::aluOpT    aluOp,
	output logic              regWrite,
	output logic              memToReg,
	output logic              memWrite,
	output logic              branch,
	output logic              branchNe,
	output logic              aluSrc,
	output logic              regDst,
	output logic              immZeroExt,
	output logic              loadUnsigned,
	output logic              illegal,
	output mipsPkg::shiftSrcT shiftSrc,
	output mipsPkg::byteMaskT readBytes,
	output mipsPkg::byteMaskT writeBytes
);
	import mipsPkg::*;

	// Access size from opcode bits 1..0
	function automatic byteMaskT sizeMask(logic [1:0] size);
		case (size)
			2'b00:   sizeMask = 4'b0001; // Byte
			2'b01:   sizeMask = 4'b0011; // Half
			default: sizeMask = 4'b1111; // Word
		endcase
	endfunction

	always_comb
	begin
		// Everything idle unless an arm below raises it
		aluOp        = aluAdd;
		regWrite     = 1'b0;
		memToReg     = 1'b0;
		memWrite     = 1'b0;
		branch       = 1'b0;
		branchNe     = 1'b0;
		aluSrc       = 1'b0;
		regDst       = 1'b0;
		immZeroExt   = 1'b0;
		loadUnsigned = 1'b0;
		illegal      = 1'b0;
		shiftSrc     = shiftShamt;
		readBytes    = 4'b0000;
		writeBytes   = 4'b0000;

		case (op)
			`OP_RTYPE:
			begin
				regDst = 1'b1; // Destination is rd
				case (funct)
					`FN_ADD:  aluOp = aluAdd;
					`FN_SUB:  aluOp = aluSub;
					`FN_AND:  aluOp = aluAnd;
					`FN_OR:   aluOp = aluOr;
					`FN_XOR:  aluOp = aluXor;
					`FN_NOR:  aluOp = aluNor;
					`FN_SLT:  aluOp = aluSlt;
					`FN_SLL:  aluOp = aluSll; // Distance from shamt field
					`FN_SRL:  aluOp = aluSrl;
					`FN_SRA:  aluOp = aluSra;
					`FN_SLLV:
					begin
						aluOp    = aluSll;
						shiftSrc = shiftRs; // Distance from rs
					end
					`FN_SRLV:
					begin
						aluOp    = aluSrl;
						shiftSrc = shiftRs;
					end
					`FN_SRAV:
					begin
						aluOp    = aluSra;
						shiftSrc = shiftRs;
					end
					default:  illegal = 1'b1; // Unknown funct
				endcase
				regWrite = !illegal;
			end
			`OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW, `OP_LWU:
			begin
				regWrite     = 1'b1;
				memToReg     = 1'b1;
				aluSrc       = 1'b1;            // Base plus offset
				loadUnsigned = op[2];           // LBU, LHU, LWU
				readBytes    = sizeMask(op[1:0]);
			end
			`OP_SB, `OP_SH, `OP_SW:
			begin
				memWrite   = 1'b1;
				aluSrc     = 1'b1;
				writeBytes = sizeMask(op[1:0]);
			end
			`OP_BEQ, `OP_BNE:
			begin
				branch   = 1'b1;
				branchNe = (op == `OP_BNE);
				aluOp    = aluSub; // Zero flag means equal
			end
			`OP_ADDI:
			begin
				regWrite = 1'b1;
				aluSrc   = 1'b1;
			end
			`OP_SLTI:
			begin
				regWrite = 1'b1;
				aluSrc   = 1'b1;
				aluOp    = aluSlt; // Signed against sign-extended imm
			end
			`OP_ANDI, `OP_ORI, `OP_XORI:
			begin
				regWrite   = 1'b1;
				aluSrc     = 1'b1;
				immZeroExt = 1'b1;
				case (op)
					`OP_ANDI: aluOp = aluAnd;
					`OP_ORI:  aluOp = aluOr;
					default:  aluOp = aluXor;
				endcase
			end
			`OP_LUI:
			begin
				regWrite   = 1'b1;
				aluSrc     = 1'b1;
				immZeroExt = 1'b1;
				aluOp      = aluSll;       // Immediate moved to upper half
				shiftSrc   = shiftSixteen;
			end
			default: illegal = 1'b1; // Unknown opcode
		endcase
	end

	// No opcode both loads a register and writes memory
	always_comb
	begin
		assert final (!(regWrite && memWrite))
			else $error("controlUnit: regWrite and memWrite for op %b", op);
	end

endmodule

// File: logic/mipsPkg.sv
package mipsPkg;

	////////////////////////////////////////////////////////////
	// Datapath widths
	////////////////////////////////////////////////////////////

	typedef logic [31:0] wordT;     // Data word and address
	typedef logic [4:0]  regIdxT;   // Register file index
	typedef logic [5:0]  opcodeT;   // Instruction bits 31..26
	typedef logic [5:0]  functT;    // R-type bits 5..0
	typedef logic [3:0]  byteMaskT; // One enable per byte lane
	typedef logic [4:0]  shamtT;    // Shift distance

	////////////////////////////////////////////////////////////
	// ALU operation select
	////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		aluAdd = 4'b0000,
		aluSub = 4'b0001, // Also the branch compare
		aluAnd = 4'b0010,
		aluOr  = 4'b0011,
		aluXor = 4'b0100,
		aluNor = 4'b0101,
		aluSll = 4'b0110,
		aluSrl = 4'b0111,
		aluSra = 4'b1000,
		aluSlt = 4'b1001  // Signed compare, result 0 or 1
	} aluOpT;

	// Where the shift distance comes from
	typedef enum logic [1:0] {
		shiftShamt   = 2'b00, // Instruction bits 10..6
		shiftRs      = 2'b01, // Low bits of rs, variable shifts
		shiftSixteen = 2'b10  // Fixed, for LUI
	} shiftSrcT;

endpackage

// File: logic/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

////////////////////////////////////////////////////////////
// Data memory
////////////////////////////////////////////////////////////

`define DMEM_WORDS 256 // Depth in 32-bit words

////////////////////////////////////////////////////////////
// Opcodes
////////////////////////////////////////////////////////////

`define OP_RTYPE 6'b000000 // Operation picked by funct
`define OP_BEQ   6'b000100
`define OP_BNE   6'b000101
`define OP_ADDI  6'b001000
`define OP_SLTI  6'b001010
`define OP_ANDI  6'b001100
`define OP_ORI   6'b001101
`define OP_XORI  6'b001110
`define OP_LUI   6'b001111
`define OP_LB    6'b100000 // Loads and stores carry the size in bits 1..0
`define OP_LH    6'b100001
`define OP_LW    6'b100011
`define OP_LBU   6'b100100 // Bit 2 marks the unsigned loads
`define OP_LHU   6'b100101
`define OP_LWU   6'b100111
`define OP_SB    6'b101000
`define OP_SH    6'b101001
`define OP_SW    6'b101011

////////////////////////////////////////////////////////////
// R-type funct codes
////////////////////////////////////////////////////////////

`define FN_SLL  6'b000000
`define FN_SRL  6'b000010
`define FN_SRA  6'b000011
`define FN_SLLV 6'b000100
`define FN_SRLV 6'b000110
`define FN_SRAV 6'b000111
`define FN_ADD  6'b100000
`define FN_SUB  6'b100010
`define FN_AND  6'b100100
`define FN_OR   6'b100101
`define FN_XOR  6'b100110
`define FN_NOR  6'b100111
`define FN_SLT  6'b101010

`endif
